/* verilog/stopwatch_pkg.sv */
`default_nettype none

package stopwatch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// run state and command encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		ST_IDLE       = 2'd0, // display blanked, counter cleared
		ST_RUNNING    = 2'd1, // counting, display follows
		ST_STOPPED    = 2'd2, // counter holds
		ST_LAP_FREEZE = 2'd3  // counting, display held
	} run_state_e;

	typedef enum logic [1:0]
	{
		CMD_START = 2'd0,
		CMD_STOP  = 2'd1,
		CMD_LAP   = 2'd2, // toggles the display freeze
		CMD_CLEAR = 2'd3  // only honoured when stopped
	} cmd_e;

	////////////////////////////////////////////////////////////////////////////
	// time format
	////////////////////////////////////////////////////////////////////////////

	localparam int BCD_W      = 4;  // bits per digit
	localparam int NUM_DIGITS = 4;  // ss.hh
	localparam int DIGITS_W   = BCD_W * NUM_DIGITS; // packed digit bus

	localparam logic [BCD_W-1:0] BCD_BLANK    = 4'd15; // display off code
	localparam logic [BCD_W-1:0] SEC_TENS_MAX = 4'd5;  // top digit stops at 5
	localparam logic [BCD_W-1:0] DEC_MAX      = 4'd9;

	// hundredth prescaler, kept tiny for simulation
	localparam int TICK_DIV = 4;
	localparam int PRESC_W  = $clog2(TICK_DIV);

	////////////////////////////////////////////////////////////////////////////
	// APB register map
	////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] ADDR_CTRL   = 8'h00; // wo, command in bits 1:0
	localparam logic [7:0] ADDR_STATUS = 8'h04; // ro, run state
	localparam logic [7:0] ADDR_TIME   = 8'h08; // ro, live digits
	localparam logic [7:0] ADDR_LAP    = 8'h0C; // ro, display digits

endpackage

`default_nettype wire

/* verilog/bcd_time_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bcd_time_if;

	// digit 3 = seconds tens ... digit 0 = hundredths units
	logic [stopwatch_pkg::NUM_DIGITS-1:0][stopwatch_pkg::BCD_W-1:0] digits;
	stopwatch_pkg::run_state_e state; // run state seen by this bus
	logic tick; // one-cycle hundredth step strobe
	logic wrap; // step from 59.99 back to 00.00

	// producer side
	modport src (output digits, output state, output tick, output wrap);

	// consumer side
	modport dst (input digits, input state, input tick, input wrap);

endinterface

`default_nettype wire

/* verilog/stopwatch_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module stopwatch_apb_regs
(
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 psel,
	input  wire logic                 penable,
	input  wire logic                 pwrite,
	input  wire logic [7:0]           paddr,
	input  wire logic [31:0]          pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	output logic                      cmd_valid, // one-cycle command strobe
	output stopwatch_pkg::cmd_e       cmd,
	input  stopwatch_pkg::run_state_e state,
	bcd_time_if.dst                   live,      // counter digits
	input  wire logic [stopwatch_pkg::DIGITS_W-1:0] lap_digits
);

	logic access; // APB access phase
	logic addr_ctrl;
	logic addr_status;
	logic addr_time;
	logic addr_lap;
	logic addr_known;
	logic ctrl_bad_bits; // junk above the command field
	logic cmd_accept;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	assign access      = psel & penable;
	assign addr_ctrl   = (paddr == stopwatch_pkg::ADDR_CTRL);
	assign addr_status = (paddr == stopwatch_pkg::ADDR_STATUS);
	assign addr_time   = (paddr == stopwatch_pkg::ADDR_TIME);
	assign addr_lap    = (paddr == stopwatch_pkg::ADDR_LAP);
	assign addr_known  = addr_ctrl | addr_status | addr_time | addr_lap;

	assign ctrl_bad_bits = |pwdata[31:2];

	// no wait states
	assign pready = 1'b1;

	// unknown address, write to a ro register, or a malformed command
	assign pslverr = access & (~addr_known
		| (pwrite & ~addr_ctrl)
		| (pwrite & addr_ctrl & ctrl_bad_bits));

	assign cmd_accept = access & pwrite & addr_ctrl & ~ctrl_bad_bits;

	////////////////////////////////////////////////////////////////////////////
	// command pulse, one cycle after the access phase
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= cmd_accept; // self-clearing strobe
	end

	// command code only matters while cmd_valid is high
	always_ff @(posedge clk)
	begin
		if (cmd_accept)
			cmd <= stopwatch_pkg::cmd_e'(pwdata[1:0]);
	end

	// read mux, same-cycle data
	always_comb
	begin
		prdata = '0;
		case (paddr)
			stopwatch_pkg::ADDR_STATUS: prdata[1:0] = state;
			stopwatch_pkg::ADDR_TIME:   prdata[stopwatch_pkg::DIGITS_W-1:0] = live.digits;
			stopwatch_pkg::ADDR_LAP:    prdata[stopwatch_pkg::DIGITS_W-1:0] = lap_digits;
			default:                    prdata = '0; // ctrl reads back zero
		endcase
	end

endmodule

`default_nettype wire

/* verilog/run_state_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module run_state_ctrl
(
	input  wire logic           clk,
	input  wire logic           rst_n,
	input  wire logic           cmd_valid,
	input  stopwatch_pkg::cmd_e cmd,
	bcd_time_if.src             ctl // only the state field is driven
);

	stopwatch_pkg::run_state_e state_q;
	stopwatch_pkg::run_state_e state_d;

	////////////////////////////////////////////////////////////////////////////
	// transition table
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q; // anything unlisted is ignored
		if (cmd_valid)
		begin
			case (state_q)
				stopwatch_pkg::ST_IDLE:
				begin
					if (cmd == stopwatch_pkg::CMD_START)
						state_d = stopwatch_pkg::ST_RUNNING;
				end
				stopwatch_pkg::ST_RUNNING:
				begin
					if (cmd == stopwatch_pkg::CMD_STOP)
						state_d = stopwatch_pkg::ST_STOPPED;
					else if (cmd == stopwatch_pkg::CMD_LAP)
						state_d = stopwatch_pkg::ST_LAP_FREEZE; // freeze display only
				end
				stopwatch_pkg::ST_LAP_FREEZE:
				begin
					if (cmd == stopwatch_pkg::CMD_LAP)
						state_d = stopwatch_pkg::ST_RUNNING; // release lap
					else if (cmd == stopwatch_pkg::CMD_STOP)
						state_d = stopwatch_pkg::ST_STOPPED;
				end
				stopwatch_pkg::ST_STOPPED:
				begin
					if (cmd == stopwatch_pkg::CMD_START)
						state_d = stopwatch_pkg::ST_RUNNING; // resume
					else if (cmd == stopwatch_pkg::CMD_CLEAR)
						state_d = stopwatch_pkg::ST_IDLE;
				end
				default: state_d = stopwatch_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= stopwatch_pkg::ST_IDLE;
		else
			state_q <= state_d;
	end

	assign ctl.state = state_q;

endmodule

`default_nettype wire

/* verilog/bcd_time_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module bcd_time_counter
(
	input  wire logic clk,
	input  wire logic rst_n,
	bcd_time_if.dst   ctl, // run state from the controller
	bcd_time_if.src   cnt  // live time out
);

	logic [stopwatch_pkg::PRESC_W-1:0] presc_q; // cycles into current hundredth
	logic [stopwatch_pkg::NUM_DIGITS-1:0][stopwatch_pkg::BCD_W-1:0] digits_q;
	logic [stopwatch_pkg::NUM_DIGITS-1:0][stopwatch_pkg::BCD_W-1:0] digits_inc;
	logic advance;   // running or lap freeze
	logic tick;
	logic carry_out; // every digit was at its limit

	// seconds tens rolls over at 5, all the rest at 9
	function automatic logic [stopwatch_pkg::BCD_W-1:0] digit_limit(input int idx);
		if (idx == stopwatch_pkg::NUM_DIGITS - 1)
			return stopwatch_pkg::SEC_TENS_MAX;
		return stopwatch_pkg::DEC_MAX;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// prescaler
	////////////////////////////////////////////////////////////////////////////

	// lap freeze keeps counting, only the display stops
	assign advance = (ctl.state == stopwatch_pkg::ST_RUNNING)
		|| (ctl.state == stopwatch_pkg::ST_LAP_FREEZE);

	// last cycle of the hundredth
	assign tick = advance
		&& (presc_q == stopwatch_pkg::PRESC_W'(stopwatch_pkg::TICK_DIV - 1));

	////////////////////////////////////////////////////////////////////////////
	// digit cascade
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		digits_inc = digits_q;
		carry_out  = 1'b1; // the step enters at hundredths units
		for (int i = 0; i < stopwatch_pkg::NUM_DIGITS; i++)
		begin
			if (carry_out)
			begin
				if (digits_q[i] == digit_limit(i))
					digits_inc[i] = '0; // roll over, carry on
				else
				begin
					digits_inc[i] = digits_q[i] + 1'b1;
					carry_out     = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			presc_q  <= '0;
			digits_q <= '0;
		end
		else
		begin
			case (ctl.state)
				stopwatch_pkg::ST_IDLE:
				begin
					presc_q  <= '0; // next start gets a full first hundredth
					digits_q <= '0;
				end
				stopwatch_pkg::ST_RUNNING, stopwatch_pkg::ST_LAP_FREEZE:
				begin
					presc_q <= tick ? '0 : presc_q + 1'b1;
					if (tick)
						digits_q <= digits_inc;
				end
				default: ; // stopped, hold everything
			endcase
		end
	end

	assign cnt.digits = digits_q;
	assign cnt.tick   = tick;
	assign cnt.wrap   = tick & carry_out; // 59.99 -> 00.00
	assign cnt.state  = ctl.state;        // state the digits belong to

endmodule

`default_nettype wire

/* verilog/lap_store.sv */
`timescale 1ns/1ps
`default_nettype none

module lap_store
(
	input  wire logic clk,
	input  wire logic rst_n,
	bcd_time_if.dst   cnt, // live counter digits
	bcd_time_if.dst   ctl, // run state
	output logic [stopwatch_pkg::DIGITS_W-1:0] disp_digits
);

	logic [stopwatch_pkg::NUM_DIGITS-1:0][stopwatch_pkg::BCD_W-1:0] disp_q;
	logic [stopwatch_pkg::NUM_DIGITS-1:0][stopwatch_pkg::BCD_W-1:0] disp_d;

	////////////////////////////////////////////////////////////////////////////
	// display select
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (ctl.state)
			stopwatch_pkg::ST_RUNNING, stopwatch_pkg::ST_STOPPED:
				disp_d = cnt.digits; // track the counter
			stopwatch_pkg::ST_LAP_FREEZE:
				disp_d = disp_q;     // hold the lap time
			default:
			begin
				// idle, every digit blanked
				for (int i = 0; i < stopwatch_pkg::NUM_DIGITS; i++)
					disp_d[i] = stopwatch_pkg::BCD_BLANK;
			end
		endcase
	end

	// one cycle behind the counter
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			disp_q <= '0; // zeros until the first edge, then blank
		else
			disp_q <= disp_d;
	end

	assign disp_digits = disp_q;

endmodule

`default_nettype wire

/* verilog/stopwatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stopwatch_top
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	// APB slave
	input  wire logic        psel,
	input  wire logic        penable,
	input  wire logic        pwrite,
	input  wire logic [7:0]  paddr,
	input  wire logic [31:0] pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	// BCD display, digit 3 in bits 15:12
	output logic [stopwatch_pkg::DIGITS_W-1:0] disp_digits
);

	logic                cmd_valid;
	stopwatch_pkg::cmd_e cmd;

	bcd_time_if cnt_bus (); // counter -> lap store, registers
	bcd_time_if ctl_bus (); // controller -> counter, lap store

	stopwatch_apb_regs u_apb_regs
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.state      (ctl_bus.state),
		.live       (cnt_bus),
		.lap_digits (disp_digits) // lap register reads the display
	);

	run_state_ctrl u_run_state_ctrl
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.ctl       (ctl_bus)
	);

	bcd_time_counter u_bcd_time_counter
	(
		.clk   (clk),
		.rst_n (rst_n),
		.ctl   (ctl_bus),
		.cnt   (cnt_bus)
	);

	lap_store u_lap_store
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.cnt         (cnt_bus),
		.ctl         (ctl_bus),
		.disp_digits (disp_digits)
	);

endmodule

`default_nettype wire

/* verification/stopwatch_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module stopwatch_assertions
(
	input wire logic                 clk,
	input wire logic                 rst_n,
	input stopwatch_pkg::run_state_e state,
	input wire logic [15:0]          live_digits, // counter, seconds tens on top
	input wire logic                 tick,
	input wire logic                 wrap,
	input wire logic [15:0]          disp_digits
);

	localparam int DIAL_HUNDREDTHS = 6000; // 00.00 .. 59.99

	// sticky per-property failure flags
	logic blank_bad  = 1'b0;
	logic range_bad  = 1'b0;
	logic step_bad   = 1'b0;
	logic wrap_bad   = 1'b0;
	logic stop_bad   = 1'b0;
	logic lap_bad    = 1'b0;
	logic follow_bad = 1'b0;
	logic any_failed; // polled from the testbench

	assign any_failed = blank_bad | range_bad | step_bad | wrap_bad
		| stop_bad | lap_bad | follow_bad;

	// ss.hh as a plain count of hundredths
	function automatic int to_hundredths(input logic [15:0] d);
		return int'(d[15:12]) * 1000 + int'(d[11:8]) * 100 + int'(d[7:4]) * 10 + int'(d[3:0]);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// time rules
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rst_n)
		live_digits[3:0] <= stopwatch_pkg::DEC_MAX && live_digits[7:4] <= stopwatch_pkg::DEC_MAX
		&& live_digits[11:8] <= stopwatch_pkg::DEC_MAX
		&& live_digits[15:12] <= stopwatch_pkg::SEC_TENS_MAX) else
	begin
		range_bad = 1'b1;
		$error("live digit out of BCD range");
	end

	// one hundredth per tick, carry included
	assert property (@(posedge clk) disable iff (!rst_n)
		tick |=> to_hundredths(live_digits)
			== (to_hundredths($past(live_digits)) + 1) % DIAL_HUNDREDTHS) else
	begin
		step_bad = 1'b1;
		$error("tick did not advance the time by one hundredth");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		wrap == (tick && live_digits == 16'h5999)) else // only 59.99 -> 00.00
	begin
		wrap_bad = 1'b1;
		$error("wrap pulse away from the 59.99 step");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		state == stopwatch_pkg::ST_STOPPED |=> live_digits == $past(live_digits)) else
	begin
		stop_bad = 1'b1;
		$error("live time moved while stopped");
	end

	////////////////////////////////////////////////////////////////////////////
	// display rules
	////////////////////////////////////////////////////////////////////////////

	// display blanks one edge after idle is seen, not on the reset edge
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && $past(state) == stopwatch_pkg::ST_IDLE
		|-> disp_digits == {4{stopwatch_pkg::BCD_BLANK}}) else
	begin
		blank_bad = 1'b1;
		$error("display not blank in idle");
	end

	// frozen display, counter keeps stepping underneath
	assert property (@(posedge clk) disable iff (!rst_n)
		state == stopwatch_pkg::ST_LAP_FREEZE |=> disp_digits == $past(disp_digits)
		&& (live_digits != $past(live_digits)) == $past(tick)) else
	begin
		lap_bad = 1'b1;
		$error("lap freeze broken");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		state == stopwatch_pkg::ST_RUNNING || state == stopwatch_pkg::ST_STOPPED
		|=> disp_digits == $past(live_digits)) else // one cycle lag
	begin
		follow_bad = 1'b1;
		$error("display does not follow the live time");
	end

endmodule

bind stopwatch_top stopwatch_assertions u_assertions
(
	.clk         (clk),
	.rst_n       (rst_n),
	.state       (ctl_bus.state),
	.live_digits (cnt_bus.digits),
	.tick        (cnt_bus.tick),
	.wrap        (cnt_bus.wrap),
	.disp_digits (disp_digits)
);

`default_nettype wire

/* verification/stopwatch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stopwatch_tb;

	localparam int TIMEOUT_CYCLES = 30000; // 24000 for the wrap stretch, rest is commands
	localparam int MAX_GAP        = 40;
	localparam logic [15:0] ALL_BLANK = 16'hFFFF;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [15:0] disp_digits;
	integer      seed;
	int          cycles;
	logic [15:0] lap_time;  // live time as the lap lands
	logic [15:0] held_time; // time right after stop
	logic [31:0] rdata;
	logic        err;

	stopwatch_top uut
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.disp_digits (disp_digits)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic expect_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
		begin
			$display("[ERROR] t=%0d ns %s expected %h got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB access, setup and access phase on falling edges
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
		output logic [31:0] rd, output logic slverr);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		#2; // mid access phase, away from the edges
		rd     = prdata;
		slverr = pslverr;
		expect_equal("pready", 32'd1, 32'(pready));
		@(negedge clk); // access completed on the edge in between
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
		input logic exp_err);
		bus_access(1'b1, addr, data, rdata, err);
		expect_equal("pslverr", 32'(exp_err), 32'(err));
	endtask

	task automatic read_expect(input logic [7:0] addr, input string name,
		input logic [31:0] exp);
		bus_access(1'b0, addr, 32'd0, rdata, err);
		expect_equal("pslverr", 32'd0, 32'(err));
		expect_equal(name, exp, rdata);
	endtask

	task automatic idle_gap();
		int n;
		n = $unsigned($random(seed)) % (MAX_GAP + 1);
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_for_wrap();
		do
			@(negedge clk);
		while (!uut.cnt_bus.wrap); // high in the cycle before 00.00
	endtask

	// cycle budget plus watch on the bound assertions
	always @(negedge clk)
	begin
		cycles = cycles + 1;
		if (uut.u_assertions.any_failed)
		begin
			$display("a concurrent assertion failed, see the error above");
			abort_run();
		end
		else if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the sequence never finished", cycles);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// command sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		seed    = 32'h98fd_1f25;
		cycles  = 0;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 8'h00;
		pwdata  = 32'd0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		expect_equal("disp_digits", 32'(ALL_BLANK), 32'(disp_digits)); // blank after 1st edge
		read_expect(stopwatch_pkg::ADDR_STATUS, "STATUS", 32'(stopwatch_pkg::ST_IDLE));
		read_expect(stopwatch_pkg::ADDR_TIME, "TIME", 32'd0);
		read_expect(stopwatch_pkg::ADDR_LAP, "LAP", 32'(ALL_BLANK));

		// illegal writes, state must stay idle
		write_reg(stopwatch_pkg::ADDR_STATUS, 32'd0, 1'b1);
		write_reg(8'h20, 32'd0, 1'b1);
		write_reg(stopwatch_pkg::ADDR_CTRL, 32'h100 | 32'(stopwatch_pkg::CMD_START), 1'b1);
		read_expect(stopwatch_pkg::ADDR_STATUS, "STATUS", 32'(stopwatch_pkg::ST_IDLE));

		// start, then clear is ignored while running
		write_reg(stopwatch_pkg::ADDR_CTRL, 32'(stopwatch_pkg::CMD_START), 1'b0);
		idle_gap();
		write_reg(stopwatch_pkg::ADDR_CTRL, 32'(stopwatch_pkg::CMD_CLEAR), 1'b0);
		idle_gap();
		read_expect(stopwatch_pkg::ADDR_STATUS, "STATUS", 32'(stopwatch_pkg::ST_RUNNING));

		// lap freeze, display keeps the live time seen with the command pulse
		write_reg(stopwatch_pkg::ADDR_CTRL, 32'(stopwatch_pkg::CMD_LAP), 1'b0);
		lap_time = uut.cnt_bus.digits; // pulse cycle, state flips on the next edge
		repeat (2 * stopwatch_pkg::TICK_DIV) @(negedge clk); // live time moves on
		idle_gap();
		read_expect(stopwatch_pkg::ADDR_LAP, "LAP", 32'(lap_time));
		write_reg(stopwatch_pkg::ADDR_CTRL, 32'(stopwatch_pkg::CMD_LAP), 1'b0); // release
		idle_gap();
		read_expect(stopwatch_pkg::ADDR_STATUS, "STATUS", 32'(stopwatch_pkg::ST_RUNNING));

		// full turn of the dial, next tick is TICK_DIV cycles after the wrap
		wait_for_wrap();
		read_expect(stopwatch_pkg::ADDR_TIME, "TIME", 32'd0);

		// stop holds the time
		write_reg(stopwatch_pkg::ADDR_CTRL, 32'(stopwatch_pkg::CMD_STOP), 1'b0);
		bus_access(1'b0, stopwatch_pkg::ADDR_TIME, 32'd0, rdata, err);
		held_time = rdata[15:0];
		idle_gap();
		read_expect(stopwatch_pkg::ADDR_TIME, "TIME", 32'(held_time));
		write_reg(stopwatch_pkg::ADDR_CTRL, 32'(stopwatch_pkg::CMD_LAP), 1'b0); // no effect
		read_expect(stopwatch_pkg::ADDR_STATUS, "STATUS", 32'(stopwatch_pkg::ST_STOPPED));

		// clear from stopped
		write_reg(stopwatch_pkg::ADDR_CTRL, 32'(stopwatch_pkg::CMD_CLEAR), 1'b0);
		idle_gap();
		read_expect(stopwatch_pkg::ADDR_STATUS, "STATUS", 32'(stopwatch_pkg::ST_IDLE));
		read_expect(stopwatch_pkg::ADDR_TIME, "TIME", 32'd0);
		read_expect(stopwatch_pkg::ADDR_LAP, "LAP", 32'(ALL_BLANK));

		repeat (4) @(negedge clk); // last properties sample
		if (!uut.u_assertions.any_failed)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
		begin
			$display("assertion failures were recorded");
			abort_run();
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
verilog/stopwatch_pkg.sv
verilog/bcd_time_if.sv
verilog/stopwatch_apb_regs.sv
verilog/run_state_ctrl.sv
verilog/bcd_time_counter.sv
verilog/lap_store.sv
verilog/stopwatch_top.sv
verification/stopwatch_assertions.sv
verification/stopwatch_tb.sv

/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP        = stopwatch_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
RUN_ARGS   = +verilator+error+limit+100
PASS_MSG   = PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
